/* i2c_settings.svh */
`ifndef I2C_SETTINGS_SVH
`define I2C_SETTINGS_SVH

// data path and FIFO sizing.
`define I2C_DATA_W        8
`define I2C_FIFO_DEPTH    4
`define I2C_PRESCALE_RST  8'd4

// register offsets on paddr.
`define I2C_ADDR_PRESCALE 8'd0
`define I2C_ADDR_CMD      8'd1
`define I2C_ADDR_STATUS   8'd2
`define I2C_ADDR_TX       8'd3
`define I2C_ADDR_RX       8'd4
`define I2C_ADDR_SLAVE    8'd5
`define I2C_ADDR_LEN      8'd6

`endif

/* i2c_pkg.sv */
`default_nettype none

`include "i2c_settings.svh"

package i2c_pkg;

    // one byte on the bus, and the unit of both FIFOs.
    typedef logic [`I2C_DATA_W-1:0] byte_t;

    // transaction descriptor handed from the register block to the engine.
    typedef struct packed {
        logic [6:0] addr;   // 7-bit slave address.
        logic       rw;     // 1 selects a read.
        logic [3:0] len;    // byte count, where 0 counts as 1.
    } i2c_cmd_t;

    // engine state as seen by software through the status register.
    typedef struct packed {
        logic busy;
        logic nack;   // held until the next accepted go.
    } i2c_status_t;

    // receive FIFO entry.
    typedef struct packed {
        byte_t data;
        logic  last;  // set on the final byte of a read.
    } rx_entry_t;

endpackage

`default_nettype wire

/* sync_fifo.sv */
`timescale 1ns/10ps
`default_nettype none

`include "i2c_settings.svh"

module sync_fifo #(
    parameter type payload_t = i2c_pkg::byte_t,
    parameter int  depth     = `I2C_FIFO_DEPTH
) (
    input  wire           pclk,
    input  wire           rst_n,
    input  wire           push,
    input  wire payload_t push_data,
    input  wire           pop,
    output payload_t      head,
    output logic          full,
    output logic          empty
);

    localparam int aw = $clog2(depth);

    payload_t   mem [depth];
    logic [aw:0] wr_ptr;   // the extra top bit tells full from empty.
    logic [aw:0] rd_ptr;
    logic        do_push;
    logic        do_pop;

    assign empty   = (wr_ptr == rd_ptr);
    assign full    = (wr_ptr[aw] != rd_ptr[aw]) && (wr_ptr[aw-1:0] == rd_ptr[aw-1:0]);
    assign do_push = push && !full;   // a push into a full FIFO is lost.
    assign do_pop  = pop && !empty;
    assign head    = mem[rd_ptr[aw-1:0]];

    always_ff @(posedge pclk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge pclk) begin
        if (do_push) begin
            mem[wr_ptr[aw-1:0]] <= push_data;
        end
    end

endmodule

`default_nettype wire

/* apb_regs.sv */
`timescale 1ns/10ps
`default_nettype none

`include "i2c_settings.svh"

module apb_regs (
    input  wire                         pclk,
    input  wire                         rst_n,
    input  wire                         psel,
    input  wire                         penable,
    input  wire                         pwrite,
    input  wire  [7:0]                  paddr,
    input  wire  i2c_pkg::byte_t        pwdata,
    output i2c_pkg::byte_t              prdata,
    output logic                        pready,
    output i2c_pkg::i2c_cmd_t           cmd,
    output logic                        go,
    output i2c_pkg::byte_t              prescale,
    input  wire  i2c_pkg::i2c_status_t  status,
    output logic                        tx_push,
    output i2c_pkg::byte_t              tx_data,
    input  wire                         tx_full,
    input  wire                         tx_empty,
    output logic                        rx_pop,
    input  wire  i2c_pkg::rx_entry_t    rx_head,
    input  wire                         rx_full,
    input  wire                         rx_empty
);

    import i2c_pkg::*;

    logic  wr_access;
    logic  rd_access;
    byte_t status_word;

    // every access finishes in its access phase.
    assign pready    = 1'b1;
    assign wr_access = psel && penable && pwrite;
    assign rd_access = psel && penable && !pwrite;

    // FIFO strobes act at the edge that closes the access phase.
    assign tx_push = wr_access && (paddr == `I2C_ADDR_TX);
    assign tx_data = pwdata;
    assign rx_pop  = rd_access && (paddr == `I2C_ADDR_RX);

    assign status_word = {
        1'b0,
        rx_head.last && !rx_empty,  // only meaningful while an entry waits.
        status.nack,
        status.busy,
        rx_empty,
        rx_full,
        tx_empty,
        tx_full
    };

    always_ff @(posedge pclk) begin
        if (!rst_n) begin
            prescale <= `I2C_PRESCALE_RST;
            cmd      <= '0;
            go       <= 1'b0;
        end else begin
            go <= wr_access && (paddr == `I2C_ADDR_CMD) && pwdata[0];
            if (wr_access) begin
                case (paddr)
                    `I2C_ADDR_PRESCALE: prescale <= pwdata;
                    `I2C_ADDR_CMD:      cmd.rw   <= pwdata[1];
                    `I2C_ADDR_SLAVE:    cmd.addr <= pwdata[6:0];
                    `I2C_ADDR_LEN:      cmd.len  <= pwdata[3:0];
                    default: ;
                endcase
            end
        end
    end

    // read data is only driven during a read access phase.
    always_comb begin
        prdata = '0;
        if (rd_access) begin
            case (paddr)
                `I2C_ADDR_PRESCALE: prdata = prescale;
                `I2C_ADDR_CMD:      prdata = {6'd0, cmd.rw, 1'b0};  // go reads back as 0.
                `I2C_ADDR_STATUS:   prdata = status_word;
                `I2C_ADDR_RX:       prdata = rx_head.data;
                `I2C_ADDR_SLAVE:    prdata = {1'b0, cmd.addr};
                `I2C_ADDR_LEN:      prdata = {4'd0, cmd.len};
                default:            prdata = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

/* i2c_bit_engine.sv */
`timescale 1ns/10ps
`default_nettype none

module i2c_bit_engine (
    input  wire                        pclk,
    input  wire                        rst_n,
    input  wire                        go,
    input  wire i2c_pkg::i2c_cmd_t     cmd,
    input  wire i2c_pkg::byte_t        prescale,
    output i2c_pkg::i2c_status_t       status,
    output logic                       tx_pop,
    input  wire i2c_pkg::byte_t        tx_data,
    input  wire                        tx_empty,
    output logic                       rx_push,
    output i2c_pkg::rx_entry_t         rx_data,
    input  wire                        sda_in,
    output logic                       scl_out,
    output logic                       sda_out
);

    import i2c_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_START,
        ST_ADDR,
        ST_ACK,
        ST_DATA,
        ST_DACK,
        ST_STOP
    } state_t;

    state_t     state;
    logic [1:0] ph;        // quarter-bit phase, 0 and 1 are SCL low.
    byte_t      cnt;
    logic       tick;
    logic       bit_end;
    logic       sample;
    logic [2:0] bit_cnt;
    logic [3:0] byte_cnt;  // bytes left, including the current one.
    byte_t      shreg;
    byte_t      tx_byte;
    logic       rw;
    logic       ack_bit;
    logic       nack;
    logic       sda_q;
    logic       last_byte;
    logic       load_tx;

    assign tick      = (state != ST_IDLE) && (cnt == '0);
    assign bit_end   = tick && (ph == 2'd3);
    assign sample    = tick && (ph == 2'd2);   // end of the first high phase.
    assign last_byte = (byte_cnt == 4'd1);

    // the next write byte is fetched when an ACK bit closes and more data follows.
    assign load_tx = bit_end && !rw && !ack_bit &&
                     ((state == ST_ACK) || ((state == ST_DACK) && !last_byte));
    assign tx_byte = tx_empty ? 8'hFF : tx_data;
    assign tx_pop  = load_tx && !tx_empty;

    assign rx_push = bit_end && rw && (state == ST_DATA) && (bit_cnt == 3'd0);
    assign rx_data = {shreg, last_byte};

    assign status  = {state != ST_IDLE, nack};
    assign scl_out = (state == ST_IDLE) || ph[1];
    assign sda_out = sda_q;

    // the START occupies the two high phases, so a transaction begins at phase 2.
    always_ff @(posedge pclk) begin
        if (!rst_n) begin
            cnt <= '0;
            ph  <= 2'd3;
        end else if (state == ST_IDLE) begin
            if (go) begin
                cnt <= prescale;
                ph  <= 2'd2;
            end
        end else if (tick) begin
            cnt <= prescale;
            ph  <= ph + 2'd1;
        end else begin
            cnt <= cnt - 8'd1;
        end
    end

    always_ff @(posedge pclk) begin
        if (!rst_n) begin
            state    <= ST_IDLE;
            sda_q    <= 1'b1;
            nack     <= 1'b0;
            ack_bit  <= 1'b0;
            rw       <= 1'b0;
            bit_cnt  <= '0;
            byte_cnt <= '0;
        end else begin
            case (state)
                ST_IDLE: if (go) begin
                    state    <= ST_START;
                    rw       <= cmd.rw;
                    byte_cnt <= (cmd.len == 4'd0) ? 4'd1 : cmd.len;
                    nack     <= 1'b0;
                end
                ST_START: if (sample) begin
                    sda_q <= 1'b0;  // SDA falls while SCL is high.
                end else if (bit_end) begin
                    state   <= ST_ADDR;
                    bit_cnt <= 3'd7;
                    sda_q   <= shreg[7];
                end
                ST_ADDR: if (bit_end) begin
                    if (bit_cnt == 3'd0) begin
                        state <= ST_ACK;
                        sda_q <= 1'b1;
                    end else begin
                        bit_cnt <= bit_cnt - 3'd1;
                        sda_q   <= shreg[7];
                    end
                end
                ST_ACK: begin
                    if (sample) begin
                        ack_bit <= sda_in;
                    end
                    if (bit_end) begin
                        if (ack_bit) begin
                            nack  <= 1'b1;
                            state <= ST_STOP;
                            sda_q <= 1'b0;
                        end else begin
                            state   <= ST_DATA;
                            bit_cnt <= 3'd7;
                            sda_q   <= rw ? 1'b1 : tx_byte[7];
                        end
                    end
                end
                ST_DATA: if (bit_end) begin
                    if (bit_cnt == 3'd0) begin
                        state <= ST_DACK;
                        sda_q <= rw ? last_byte : 1'b1;  // the master NACKs the last read byte.
                    end else begin
                        bit_cnt <= bit_cnt - 3'd1;
                        sda_q   <= rw ? 1'b1 : shreg[7];
                    end
                end
                ST_DACK: begin
                    if (sample) begin
                        ack_bit <= sda_in;
                    end
                    if (bit_end) begin
                        if (!rw && ack_bit) begin
                            nack  <= 1'b1;
                            state <= ST_STOP;
                            sda_q <= 1'b0;
                        end else if (last_byte) begin
                            state <= ST_STOP;
                            sda_q <= 1'b0;
                        end else begin
                            byte_cnt <= byte_cnt - 4'd1;
                            state    <= ST_DATA;
                            bit_cnt  <= 3'd7;
                            sda_q    <= rw ? 1'b1 : tx_byte[7];
                        end
                    end
                end
                ST_STOP: begin
                    if (sample) begin
                        sda_q <= 1'b1;  // SDA rises while SCL is high.
                    end
                    if (bit_end) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // shifting left at each sample both exposes the next transmit bit and collects read data.
    always_ff @(posedge pclk) begin
        if ((state == ST_IDLE) && go) begin
            shreg <= {cmd.addr, cmd.rw};
        end else if (sample && ((state == ST_ADDR) || (state == ST_DATA))) begin
            shreg <= {shreg[6:0], sda_in};
        end else if (load_tx) begin
            shreg <= tx_byte;
        end
    end

endmodule

`default_nettype wire

/* i2c_master_top.sv */
`timescale 1ns/10ps
`default_nettype none

module i2c_master_top (
    input  wire                  pclk,
    input  wire                  rst_n,
    input  wire                  psel,
    input  wire                  penable,
    input  wire                  pwrite,
    input  wire [7:0]            paddr,
    input  wire i2c_pkg::byte_t  pwdata,
    output wire i2c_pkg::byte_t  prdata,
    output wire                  pready,
    input  wire                  sda_in,
    output wire                  scl_out,
    output wire                  sda_out
);

    import i2c_pkg::*;

    i2c_cmd_t    cmd;
    logic        go;
    byte_t       prescale;
    i2c_status_t status;
    logic        tx_push;
    byte_t       tx_wdata;
    logic        tx_pop;
    byte_t       tx_head;
    logic        tx_full;
    logic        tx_empty;
    logic        rx_push;
    rx_entry_t   rx_wdata;
    logic        rx_pop;
    rx_entry_t   rx_head;
    logic        rx_full;
    logic        rx_empty;

    apb_regs u_regs (
        .pclk     (pclk),
        .rst_n    (rst_n),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .paddr    (paddr),
        .pwdata   (pwdata),
        .prdata   (prdata),
        .pready   (pready),
        .cmd      (cmd),
        .go       (go),
        .prescale (prescale),
        .status   (status),
        .tx_push  (tx_push),
        .tx_data  (tx_wdata),
        .tx_full  (tx_full),
        .tx_empty (tx_empty),
        .rx_pop   (rx_pop),
        .rx_head  (rx_head),
        .rx_full  (rx_full),
        .rx_empty (rx_empty)
    );

    sync_fifo #(.payload_t(byte_t)) u_tx_fifo (
        .pclk      (pclk),
        .rst_n     (rst_n),
        .push      (tx_push),
        .push_data (tx_wdata),
        .pop       (tx_pop),
        .head      (tx_head),
        .full      (tx_full),
        .empty     (tx_empty)
    );

    i2c_bit_engine u_engine (
        .pclk     (pclk),
        .rst_n    (rst_n),
        .go       (go),
        .cmd      (cmd),
        .prescale (prescale),
        .status   (status),
        .tx_pop   (tx_pop),
        .tx_data  (tx_head),
        .tx_empty (tx_empty),
        .rx_push  (rx_push),
        .rx_data  (rx_wdata),
        .sda_in   (sda_in),
        .scl_out  (scl_out),
        .sda_out  (sda_out)
    );

    // received bytes wait here until software reads the receive register.
    sync_fifo #(.payload_t(rx_entry_t)) u_rx_fifo (
        .pclk      (pclk),
        .rst_n     (rst_n),
        .push      (rx_push),
        .push_data (rx_wdata),
        .pop       (rx_pop),
        .head      (rx_head),
        .full      (rx_full),
        .empty     (rx_empty)
    );

endmodule

`default_nettype wire

/* i2c_master_chk.sv */
`timescale 1ns/10ps
`default_nettype none

module i2c_master_chk (
    input wire                        pclk,
    input wire                        rst_n,
    input wire                        pready,
    input wire                        go,
    input wire                        scl_out,
    input wire                        sda_out,
    input wire i2c_pkg::i2c_status_t  status
);

    a_pready_high: assert property (@(posedge pclk) disable iff (!rst_n) pready)
        else $error("pready went low");

    // with SCL held high, a falling SDA is a START and only happens inside a transaction.
    a_start_shape: assert property (@(posedge pclk) disable iff (!rst_n)
        (scl_out && $past(scl_out) && $fell(sda_out)) |-> status.busy)
        else $error("SDA fell while SCL was high outside a START");

    // a rising SDA under high SCL is the STOP, after which SCL stays high.
    a_stop_shape: assert property (@(posedge pclk) disable iff (!rst_n)
        (scl_out && $past(scl_out) && $rose(sda_out)) |-> status.busy ##1 scl_out)
        else $error("SDA rose while SCL was high outside a STOP");

    // only a go taken from idle may start busy or clear the sticky nack.
    a_busy_from_idle_go: assert property (@(posedge pclk) disable iff (!rst_n)
        ($rose(status.busy) || $fell(status.nack)) |-> ($past(go) && !$past(status.busy)))
        else $error("busy rose or nack cleared without a go accepted from idle");

    a_scl_idle_high: assert property (@(posedge pclk) disable iff (!rst_n)
        !status.busy |-> scl_out)
        else $error("scl_out low while the engine is idle");

endmodule

bind i2c_master_top i2c_master_chk u_chk (
    .pclk    (pclk),
    .rst_n   (rst_n),
    .pready  (pready),
    .go      (go),
    .scl_out (scl_out),
    .sda_out (sda_out),
    .status  (status)
);

`default_nettype wire

/* tb_bus_monitor.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_bus_monitor (
    input  wire                        pclk,
    input  wire                        rst_n,
    input  wire                        scl,
    input  wire                        sda,
    input  wire i2c_pkg::i2c_cmd_t     exp_cmd,
    input  wire i2c_pkg::byte_t [3:0]  exp_data,
    input  wire i2c_pkg::byte_t        exp_prescale,
    output int                         errors,
    output int                         frames,
    output int                         hi_checks
);

    import i2c_pkg::*;

    localparam logic [6:0] slave_addr = 7'h2A;

    logic       scl_p;
    logic       sda_p;
    logic       in_frame;
    logic       hi_valid;     // set once SCL rose inside a frame.
    logic [3:0] bit_cnt;
    byte_t      shift;
    int         hi_len;
    logic [8:0] seen [$];     // {byte, ack bit} per slot, in bus order.

    // builds the slots a transaction should show, where an ack bit of 0 means ACK.
    function automatic int expected_frame(input i2c_cmd_t c, input byte_t [3:0] d,
                                          output logic [15:0][8:0] fr);
        int   n;
        int   len;
        logic addr_ack;
        fr = '0;
        addr_ack = (c.addr == slave_addr) ? 1'b0 : 1'b1;
        fr[0] = {c.addr, c.rw, addr_ack};
        n = 1;
        len = (c.len == 4'd0) ? 1 : int'(c.len);
        if (!addr_ack) begin
            for (int i = 0; i < len; i++) begin
                fr[n] = {d[i % 4], c.rw && (i == len - 1)};  // the last read byte is NACKed.
                n++;
            end
        end
        return n;
    endfunction

    task automatic check_frame();
        logic [15:0][8:0] fr;
        int               n;
        n = expected_frame(exp_cmd, exp_data, fr);
        frames++;
        if (seen.size() != n) begin
            $display("ERR %0t frame_slots expected %0d actual %0d", $time, n, seen.size());
            errors++;
        end
        for (int i = 0; i < n && i < seen.size(); i++) begin
            if (seen[i] !== fr[i]) begin
                $display("ERR %0t frame_slot[%0d] expected %03h actual %03h",
                         $time, i, fr[i], seen[i]);
                errors++;
            end
        end
    endtask

    always @(posedge pclk) begin
        if (!rst_n) begin
            scl_p     = 1'b1;
            sda_p     = 1'b1;
            in_frame  = 1'b0;
            hi_valid  = 1'b0;
            bit_cnt   = '0;
            shift     = '0;
            hi_len    = 0;
            errors    = 0;
            frames    = 0;
            hi_checks = 0;
            seen.delete();
        end else begin
            if (scl && scl_p && sda_p && !sda) begin
                in_frame = 1'b1;   // START.
                bit_cnt  = '0;
                hi_valid = 1'b0;
                seen.delete();
            end else if (scl && scl_p && !sda_p && sda && in_frame) begin
                in_frame = 1'b0;   // STOP.
                check_frame();
            end else if (scl && !scl_p && in_frame) begin
                if (bit_cnt == 4'd8) begin
                    seen.push_back({shift, sda});
                    bit_cnt = '0;
                end else begin
                    shift   = {shift[6:0], sda};
                    bit_cnt = bit_cnt + 4'd1;
                end
            end

            if (scl && !scl_p) begin
                hi_valid = in_frame;
                hi_len   = 1;
            end else if (scl) begin
                hi_len++;
            end else if (scl_p && hi_valid) begin
                hi_checks++;
                if (hi_len != 2 * (int'(exp_prescale) + 1)) begin
                    $display("ERR %0t scl_high_cycles expected %0d actual %0d",
                             $time, 2 * (int'(exp_prescale) + 1), hi_len);
                    errors++;
                end
                hi_valid = 1'b0;
            end
            scl_p = scl;
            sda_p = sda;
        end
    end

endmodule

`default_nettype wire

/* tb_i2c_master.sv */
`timescale 1ns/10ps
`default_nettype none

`include "i2c_settings.svh"

module tb_i2c_master;

    import i2c_pkg::*;

    localparam logic [6:0]  slave_addr = 7'h2A;
    localparam logic [31:0] seed       = 32'd43522;

    function automatic int test_budget(input int bytes, input int presc);
        return (bytes + 3) * 9 * 4 * (presc + 1) + 200;
    endfunction

    localparam int cycle_limit = test_budget(0, 4) + test_budget(3, 4) + test_budget(4, 4) +
                                 test_budget(0, 4) + test_budget(1, 4) + test_budget(4, 4) +
                                 test_budget(2, 2);

    logic            pclk;
    logic            rst_n;
    logic            psel;
    logic            penable;
    logic            pwrite;
    logic [7:0]      paddr;
    byte_t           pwdata;
    wire  [7:0]      prdata;
    wire             pready;
    wire             scl_out;
    wire             sda_out;
    wire             sda_line;
    i2c_cmd_t        exp_cmd;
    byte_t [3:0]     exp_data;
    byte_t           exp_prescale;
    int              mon_errors;
    int              mon_frames;
    int              mon_hi;
    int              tb_errors;
    int              err_mark;
    int              exp_frames;
    int              tests_passed;
    int              tests_failed;
    int              cycles;
    logic [31:0]     tx_rng;
    logic [31:0]     rx_rng;

    // slave model state.
    logic            slave_drive = 1'b1;
    logic            s_scl;
    logic            s_sda;
    logic            s_active;
    logic            s_addr_phase;
    logic            s_reading;
    logic            s_master_nack;
    logic [3:0]      s_rises;
    byte_t           s_shift;
    byte_t           s_rd_byte;
    logic [31:0]     slave_rng;
    logic [31:0]     s_next;

    assign sda_line = sda_out & slave_drive;   // open-drain wired AND.

    i2c_master_top u_i2c_master_top (
        .pclk    (pclk),
        .rst_n   (rst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .sda_in  (sda_line),
        .scl_out (scl_out),
        .sda_out (sda_out)
    );

    tb_bus_monitor u_monitor (
        .pclk         (pclk),
        .rst_n        (rst_n),
        .scl          (scl_out),
        .sda          (sda_line),
        .exp_cmd      (exp_cmd),
        .exp_data     (exp_data),
        .exp_prescale (exp_prescale),
        .errors       (mon_errors),
        .frames       (mon_frames),
        .hi_checks    (mon_hi)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    initial begin
        pclk = 1'b0;
        forever #50 pclk = ~pclk;
    end

    initial begin
        cycles = 0;
        while (cycles < cycle_limit) begin
            @(posedge pclk);
            cycles++;
        end
        $display("timeout: the run did not finish within %0d cycles", cycle_limit);
        $display("RESULT: FAIL");
        $finish;
    end

    // slave at 0x2A, watching the bus on the falling pclk edge and driving during SCL low.
    always @(negedge pclk) begin
        if (!rst_n) begin
            slave_drive   <= 1'b1;
            s_scl         <= 1'b1;
            s_sda         <= 1'b1;
            s_active      <= 1'b0;
            s_addr_phase  <= 1'b0;
            s_reading     <= 1'b0;
            s_master_nack <= 1'b0;
            s_rises       <= '0;
            s_shift       <= '0;
            s_rd_byte     <= '0;
            slave_rng     <= seed;
        end else begin
            s_scl <= scl_out;
            s_sda <= sda_line;
            if (s_scl && scl_out && s_sda && !sda_line) begin
                s_active      <= 1'b1;
                s_addr_phase  <= 1'b1;
                s_reading     <= 1'b0;
                s_master_nack <= 1'b0;
                s_rises       <= '0;
                slave_drive   <= 1'b1;
            end else if (s_scl && scl_out && !s_sda && sda_line) begin
                s_active    <= 1'b0;
                slave_drive <= 1'b1;
            end else if (s_active && !s_scl && scl_out) begin
                if (s_rises < 4'd8) begin
                    s_shift <= {s_shift[6:0], sda_line};
                end else if (!s_addr_phase) begin
                    s_master_nack <= sda_line;
                end
                s_rises <= s_rises + 4'd1;
            end else if (s_active && s_scl && !scl_out && (s_rises != 4'd0)) begin
                if (s_rises == 4'd8) begin
                    if (s_addr_phase) begin
                        s_reading   <= s_shift[0];
                        slave_drive <= (s_shift[7:1] != slave_addr);
                        s_active    <= (s_shift[7:1] == slave_addr);
                    end else begin
                        slave_drive <= s_reading;  // a read leaves the ack bit to the master.
                    end
                end else if (s_rises == 4'd9) begin
                    s_rises      <= '0;
                    s_addr_phase <= 1'b0;
                    if (s_reading && (s_addr_phase || !s_master_nack)) begin
                        s_next = xorshift(slave_rng);
                        slave_rng   <= s_next;
                        s_rd_byte   <= s_next[7:0];
                        slave_drive <= s_next[7];
                    end else begin
                        slave_drive <= 1'b1;
                    end
                end else if (s_reading && !s_addr_phase) begin
                    slave_drive <= s_rd_byte[3'd7 - s_rises[2:0]];
                end
            end
        end
    end

    task automatic apb_write(input logic [7:0] addr, input byte_t data);
        @(negedge pclk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(negedge pclk);
        penable = 1'b1;
        @(negedge pclk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_read(input logic [7:0] addr, output byte_t data);
        @(negedge pclk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(negedge pclk);
        penable = 1'b1;
        @(posedge pclk);
        data = prdata;   // taken at the edge that completes the access.
        @(negedge pclk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        if (exp !== act) begin
            $display("ERR %0t %s expected %0h actual %0h", $time, name, exp, act);
            tb_errors++;
        end
    endtask

    task automatic next_byte(inout logic [31:0] state, output byte_t b);
        state = xorshift(state);
        b = state[7:0];
    endtask

    task automatic wait_idle(output byte_t st);
        do begin
            apb_read(`I2C_ADDR_STATUS, st);
        end while (st[4]);
    endtask

    task automatic run_transaction(input logic [6:0] addr, input logic rw,
                                   input logic [3:0] len, output byte_t st);
        exp_cmd = '{addr: addr, rw: rw, len: len};
        apb_write(`I2C_ADDR_SLAVE, {1'b0, addr});
        apb_write(`I2C_ADDR_LEN, {4'd0, len});
        apb_write(`I2C_ADDR_CMD, {6'd0, rw, 1'b1});
        exp_frames++;
        wait_idle(st);
        check_value("monitor_frames", exp_frames, mon_frames);
    endtask

    task automatic begin_test();
        err_mark = tb_errors + mon_errors;
    endtask

    task automatic end_test(input string name);
        if (tb_errors + mon_errors == err_mark) begin
            $display("test %s: passed", name);
            tests_passed++;
        end else begin
            $display("test %s: failed", name);
            tests_failed++;
        end
    endtask

    initial begin
        byte_t st;
        byte_t b;
        int    hi_mark;
        psel         = 1'b0;
        penable      = 1'b0;
        pwrite       = 1'b0;
        paddr        = '0;
        pwdata       = '0;
        rst_n        = 1'b0;
        exp_cmd      = '0;
        exp_data     = '0;
        exp_prescale = `I2C_PRESCALE_RST;
        tb_errors    = 0;
        err_mark     = 0;
        exp_frames   = 0;
        tests_passed = 0;
        tests_failed = 0;
        tx_rng       = seed;
        rx_rng       = seed;
        repeat (2) @(negedge pclk);
        rst_n = 1'b1;

        begin_test();
        apb_read(`I2C_ADDR_STATUS, st);
        check_value("status", 8'h0A, st);
        check_value("scl_out", 1, scl_out);
        check_value("sda_out", 1, sda_out);
        check_value("pready", 1, pready);
        end_test("reset");

        begin_test();
        for (int i = 0; i < 3; i++) begin
            next_byte(tx_rng, b);
            exp_data[i] = b;
            apb_write(`I2C_ADDR_TX, b);
        end
        run_transaction(slave_addr, 1'b0, 4'd3, st);
        check_value("status", 8'h0A, st);
        end_test("write");

        begin_test();
        for (int i = 0; i < 4; i++) begin
            next_byte(rx_rng, b);
            exp_data[i] = b;
        end
        run_transaction(slave_addr, 1'b1, 4'd4, st);
        for (int i = 0; i < 4; i++) begin
            apb_read(`I2C_ADDR_STATUS, st);
            check_value("status.rx_last", (i == 3), st[6]);
            apb_read(`I2C_ADDR_RX, b);
            check_value("rx_data", exp_data[i], b);
        end
        end_test("read");

        begin_test();
        run_transaction(7'h11, 1'b0, 4'd1, st);
        check_value("status", 8'h2A, st);
        next_byte(tx_rng, b);
        exp_data[0] = b;
        apb_write(`I2C_ADDR_TX, b);
        run_transaction(slave_addr, 1'b0, 4'd1, st);
        check_value("status", 8'h0A, st);
        end_test("address_nack");

        begin_test();
        for (int i = 0; i < `I2C_FIFO_DEPTH + 1; i++) begin
            next_byte(tx_rng, b);
            if (i < 4) begin
                exp_data[i] = b;
            end
            apb_write(`I2C_ADDR_TX, b);
            apb_read(`I2C_ADDR_STATUS, st);
            check_value("status.tx_full", (i >= `I2C_FIFO_DEPTH - 1), st[0]);
        end
        run_transaction(slave_addr, 1'b0, 4'd4, st);
        check_value("status", 8'h0A, st);
        end_test("fifo_full");

        begin_test();
        apb_write(`I2C_ADDR_PRESCALE, 8'd2);
        exp_prescale = 8'd2;
        hi_mark = mon_hi;
        for (int i = 0; i < 2; i++) begin
            next_byte(tx_rng, b);
            exp_data[i] = b;
            apb_write(`I2C_ADDR_TX, b);
        end
        run_transaction(slave_addr, 1'b0, 4'd2, st);
        check_value("scl_high_periods", 27, mon_hi - hi_mark);  // three 9-bit slots.
        end_test("prescale");

        $display("tests passed %0d failed %0d errors %0d",
                 tests_passed, tests_failed, tb_errors + mon_errors);
        if (tests_failed == 0 && tb_errors + mon_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
+incdir+.
i2c_pkg.sv
sync_fifo.sv
apb_regs.sv
i2c_bit_engine.sv
i2c_master_top.sv
i2c_master_chk.sv
tb_bus_monitor.sv
tb_i2c_master.sv

/* run.sh */
#!/bin/bash
# builds and runs the testbench with Verilator; the log decides pass or fail.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_i2c_master \
    -o tb_sim > build.log 2>&1 \
    && ./obj_dir/tb_sim > sim.log 2>&1 \
    || echo "build or simulation ended with an error"
grep -q "RESULT: PASS" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
